// File: bench/mem_subsystem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_sva
    import sramx_pkg::*, axi_pkg::*;
(
    input logic                  clk,
    input logic                  resetn,
    input logic                  push,
    input logic                  pop,
    input logic                  data_ok,
    input logic                  awvalid,
    input logic                  awready,
    input logic [axi_addr_w-1:0] awaddr,
    input logic                  wvalid,
    input logic                  wready,
    input logic [axi_data_w-1:0] wdata,
    input logic [axi_strb_w-1:0] wstrb,
    input logic                  arvalid,
    input logic                  arready,
    input logic [axi_addr_w-1:0] araddr
);

    int occupancy;       // entries holding a slot
    int outstanding;     // accepted, not yet completed towards the cpu
    int fail_count = 0;  // assertion failures so far

    always_ff @(posedge clk) begin
        if (resetn) begin
            occupancy   <= 0;
            outstanding <= 0;
        end else begin
            occupancy   <= occupancy + int'(push) - int'(pop);
            outstanding <= outstanding + int'(push) - int'(data_ok);
        end
    end

    assert property (@(posedge clk) disable iff (resetn) occupancy <= lsb_depth)
        else begin
            $error("buffer holds more than lsb_depth entries");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (resetn) data_ok |-> outstanding > 0)
        else begin
            $error("data_ok with no request pending");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (resetn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("AW channel changed before awready");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (resetn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            $error("W channel changed before wready");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (resetn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("AR channel changed before arready");
            fail_count++;
        end

endmodule

bind load_store_buffer mem_subsystem_sva lsb_checks (
    .clk     (clk),
    .resetn  (resetn),
    .push    (push),
    .pop     (pop),
    .data_ok (data_ok),
    .awvalid (1'b0),
    .awready (1'b0),
    .awaddr  ('0),
    .wvalid  (1'b0),
    .wready  (1'b0),
    .wdata   ('0),
    .wstrb   ('0),
    .arvalid (1'b0),
    .arready (1'b0),
    .araddr  ('0)
);

bind sramx_axi_bridge mem_subsystem_sva axi_checks (
    .clk     (clk),
    .resetn  (resetn),
    .push    (1'b0),
    .pop     (1'b0),
    .data_ok (1'b0),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata_axi),
    .wstrb   (wstrb),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr)
);

`default_nettype wire

// File: bench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
    import sramx_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 8;
    localparam int max_requests    = 200;
    localparam int cycles_per_req  = 20;
    localparam int random_requests = 160;
    localparam int ref_bytes       = 128;  // small window so addresses collide often

    logic                    clk;
    logic                    resetn;
    logic                    req;
    logic                    wr;
    size_t                   size;
    logic [sramx_addr_w-1:0] addr;
    logic [sramx_data_w-1:0] wdata;
    logic                    addr_ok;
    logic                    data_ok;
    logic [sramx_data_w-1:0] rdata;

    logic [7:0]              ref_mem [ref_bytes];
    logic                    kind_q [$];  // 1 for a store, acceptance order
    logic [sramx_data_w-1:0] exp_q [$];
    int                      pending_cnt;
    int                      store_pending;
    int                      accepted_cnt;
    logic                    front_is_load;
    logic [sramx_data_w-1:0] exp_rdata;
    logic                    store_acc;

    mem_subsystem_top UUT (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .wr      (wr),
        .size    (size),
        .addr    (addr),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [sramx_data_w-1:0] expected_load(size_t sz, logic [6:0] a);
        case (sz)
            size_byte: return {24'h0, ref_mem[a]};
            size_half: return {16'h0, ref_mem[a + 1], ref_mem[a]};
            default:   return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
        endcase
    endfunction

    function automatic logic [sramx_addr_w-1:0] pick_addr(size_t sz, logic [31:0] raw);
        case (sz)
            size_byte: return {25'h0, raw[6:0]};
            size_half: return {25'h0, raw[6:1], 1'b0};
            default:   return {25'h0, raw[6:2], 2'b00};
        endcase
    endfunction

    // failures seen by the bound buffer and AXI checkers
    function automatic int protocol_errors();
        return UUT.u_lsb.lsb_checks.fail_count + UUT.u_bridge.axi_checks.fail_count;
    endfunction

    task automatic apply_store(size_t sz, logic [6:0] a, logic [sramx_data_w-1:0] d);
        int n;
        n = (sz == size_byte) ? 1 : (sz == size_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + i] = d[i*8 +: 8];  // little endian lanes
        end
    endtask

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send(input logic is_wr, input size_t sz, input logic [31:0] a,
                        input logic [31:0] d);
        logic taken;
        req   = 1'b1;
        wr    = is_wr;
        size  = sz;
        addr  = a;
        wdata = d;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = addr_ok;
            #1;
        end
        req = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // reference model, updated at each acceptance and completion
    always @(posedge clk) begin
        if (resetn) begin
            kind_q.delete();
            exp_q.delete();
            store_pending = 0;
            accepted_cnt  = 0;
        end else begin
            if (data_ok && kind_q.size() > 0) begin
                if (kind_q[0]) begin
                    store_pending--;
                end else begin
                    void'(exp_q.pop_front());
                end
                void'(kind_q.pop_front());
            end
            if (req && addr_ok) begin
                accepted_cnt++;
                kind_q.push_back(wr);
                if (wr) begin
                    apply_store(size, addr[6:0], wdata);
                    store_pending++;
                end else begin
                    exp_q.push_back(expected_load(size, addr[6:0]));
                end
            end
        end
        pending_cnt   = kind_q.size();
        front_is_load = (kind_q.size() > 0) && !kind_q[0];
        if (exp_q.size() > 0) begin
            exp_rdata = exp_q[0];
        end else begin
            exp_rdata = '0;
        end
    end

    always @(posedge clk) begin
        if (protocol_errors() != 0) begin
            fail_run("a bound protocol assertion on the buffer or the AXI channels failed");
        end
    end

    assign store_acc = req && addr_ok && wr;

    idle_addr_ok: assert property (@(posedge clk) disable iff (resetn)
        accepted_cnt == 0 |-> addr_ok)
    else fail_run($sformatf("Mismatch at %0t: addr_ok got %b expected 1",
                            $time, $sampled(addr_ok)));

    idle_data_ok: assert property (@(posedge clk) disable iff (resetn)
        accepted_cnt == 0 |-> !data_ok)
    else fail_run($sformatf("Mismatch at %0t: data_ok got %b expected 0",
                            $time, $sampled(data_ok)));

    load_value: assert property (@(posedge clk) disable iff (resetn)
        data_ok && front_is_load |-> rdata == exp_rdata)
    else fail_run($sformatf("Mismatch at %0t: rdata got %h expected %h",
                            $time, $sampled(rdata), $sampled(exp_rdata)));

    store_ack_timing: assert property (@(posedge clk) disable iff (resetn)
        store_acc |=> data_ok && !front_is_load)
    else fail_run($sformatf("Mismatch at %0t: data_ok got %b expected 1 for a store",
                            $time, $sampled(data_ok)));

    store_ack_source: assert property (@(posedge clk) disable iff (resetn)
        data_ok && !front_is_load |-> $past(store_acc))
    else fail_run($sformatf("Mismatch at %0t: data_ok got 1 expected 0", $time));

    load_waits_for_stores: assert property (@(posedge clk) disable iff (resetn)
        req && !wr && store_pending != 0 |-> !addr_ok)
    else fail_run($sformatf("Mismatch at %0t: addr_ok got %b expected 0 for a load",
                            $time, $sampled(addr_ok)));

    initial begin
        #(clk_period * (reset_cycles + max_requests * cycles_per_req));
        fail_run("timeout: the requests did not drain before the watchdog expired");
    end

    initial begin
        size_t sz;
        clk           = 1'b0;
        resetn        = 1'b1;
        req           = 1'b0;
        wr            = 1'b0;
        size          = size_word;
        addr          = '0;
        wdata         = '0;
        pending_cnt   = 0;
        store_pending = 0;
        accepted_cnt  = 0;
        front_is_load = 1'b0;
        exp_rdata     = '0;
        for (int i = 0; i < ref_bytes; i++) begin
            ref_mem[i] = 8'h00;  // ram powers up cleared
        end
        void'($urandom(32'h9b2c_0933));

        repeat (reset_cycles) @(posedge clk);
        #1;
        resetn = 1'b0;
        idle(4);

        send(1'b1, size_word, 32'h10, 32'hdead_beef);
        send(1'b0, size_word, 32'h10, '0);  // held back until the store drains

        for (int i = 0; i < 4; i++) begin
            send(1'b1, size_byte, 32'h20 + i, 32'hffff_ff00 | (8'h11 * (i + 1)));
        end
        send(1'b1, size_half, 32'h24, 32'hcafe_1234);
        send(1'b1, size_half, 32'h26, 32'h5678_abcd);
        send(1'b0, size_byte, 32'h21, '0);
        send(1'b0, size_half, 32'h22, '0);
        send(1'b0, size_half, 32'h26, '0);
        send(1'b0, size_word, 32'h20, '0);
        send(1'b0, size_word, 32'h24, '0);

        // more stores than the buffer holds, then back to back loads
        for (int i = 0; i < 6; i++) begin
            send(1'b1, size_word, 32'h30 + 4 * i, $urandom());
        end
        for (int i = 0; i < 5; i++) begin
            send(1'b0, size_word, 32'h30 + 4 * i, '0);
        end

        for (int n = 0; n < random_requests; n++) begin
            sz = size_t'($urandom_range(2));
            send($urandom_range(1), sz, pick_addr(sz, $urandom()), $urandom());
            if ($urandom_range(3) == 0) begin
                idle($urandom_range(2));
            end
        end

        while (pending_cnt != 0) begin
            @(posedge clk);
            #1;
        end
        idle(10);  // let the last posted writes reach the ram
        if (protocol_errors() != 0) begin
            fail_run("a bound protocol assertion on the buffer or the AXI channels failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/sramx_pkg.sv
verilog/axi_pkg.sv
verilog/load_store_buffer.sv
verilog/sramx_axi_bridge.sv
verilog/axi_lite_ram.sv
verilog/mem_subsystem_top.sv
bench/mem_subsystem_sva.sv
bench/tb_mem_subsystem.sv

// File: verilog/axi_lite_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ram
    import axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  awvalid,
    output logic                  awready,
    input  logic [axi_addr_w-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [axi_data_w-1:0] wdata,
    input  logic [axi_strb_w-1:0] wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,

    input  logic                  arvalid,
    output logic                  arready,
    input  logic [axi_addr_w-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [axi_data_w-1:0] rdata,
    output logic [1:0]            rresp
);

    logic [axi_data_w-1:0]  mem [ram_words];

    logic                   wr_accept;  // drives both awready and wready
    logic                   wr_fire;
    logic                   rd_fire;
    logic [ram_index_w-1:0] wr_index;
    logic [ram_index_w-1:0] rd_index;

    // block ram powers up cleared
    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    assign wr_index = awaddr[2 +: ram_index_w];
    assign rd_index = araddr[2 +: ram_index_w];

    assign awready  = wr_accept;
    assign wready   = wr_accept;
    assign wr_fire  = awvalid && awready && wvalid && wready;
    assign rd_fire  = arvalid && arready;

    assign bresp    = resp_okay;
    assign rresp    = resp_okay;

    always_ff @(posedge clk) begin
        if (resetn) begin
            wr_accept <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;  // one read outstanding
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < axi_strb_w; i++) begin
                if (wstrb[i]) begin
                    mem[wr_index][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

// File: verilog/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_strb_w = axi_data_w / 8;

    localparam logic [1:0] resp_okay = 2'b00;  // the only response ever returned

    // backing store of the slave ram
    localparam int ram_words   = 1024;
    localparam int ram_index_w = $clog2(ram_words);

endpackage

`default_nettype wire

// File: verilog/load_store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_buffer
    import sramx_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,

    input  logic                    req,
    input  logic                    wr,
    input  size_t                   size,
    input  logic [sramx_addr_w-1:0] addr,
    input  logic [sramx_data_w-1:0] wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [sramx_data_w-1:0] rdata,

    output logic                    q_req,
    output logic                    q_wr,
    output size_t                   q_size,
    output logic [sramx_addr_w-1:0] q_addr,
    output logic [sramx_data_w-1:0] q_wdata,
    input  logic                    b_addr_ok,
    input  logic                    b_data_ok,
    input  logic [sramx_data_w-1:0] b_rdata
);

    logic [lsb_index_w-1:0]  head;     // next slot to fill
    logic [lsb_index_w-1:0]  tail;     // oldest pending entry

    logic                    e_free  [lsb_depth];
    logic                    e_issue [lsb_depth];  // not yet taken by the bridge
    logic                    e_wr    [lsb_depth];
    size_t                   e_size  [lsb_depth];
    logic [sramx_addr_w-1:0] e_addr  [lsb_depth];
    logic [sramx_data_w-1:0] e_wdata [lsb_depth];

    logic                    empty;
    logic                    has_room;
    logic                    push;
    logic                    pop;
    logic                    wr_ack;   // posted store acknowledge

    assign empty    = e_free[tail];
    assign has_room = e_free[head];

    // only one kind of request may sit in the queue at a time
    assign addr_ok  = has_room && (empty || wr == e_wr[tail]);
    assign push     = req && addr_ok;
    assign pop      = b_data_ok;

    always_ff @(posedge clk) begin
        if (resetn) begin
            head   <= '0;
            tail   <= '0;
            wr_ack <= 1'b0;
            for (int i = 0; i < lsb_depth; i++) begin
                e_free[i]  <= 1'b1;
                e_issue[i] <= 1'b0;
                e_wr[i]    <= 1'b0;
            end
        end else begin
            wr_ack <= push && wr;

            for (int i = 0; i < lsb_depth; i++) begin
                if (push && head == lsb_index_w'(i)) begin
                    e_free[i]  <= 1'b0;
                    e_issue[i] <= 1'b1;
                    e_wr[i]    <= wr;
                end else begin
                    if (pop && tail == lsb_index_w'(i)) begin
                        e_free[i] <= 1'b1;
                    end
                    if (b_addr_ok && tail == lsb_index_w'(i)) begin
                        e_issue[i] <= 1'b0;  // slot kept until the response
                    end
                end
            end

            if (push) begin
                head <= head + 1'b1;
            end
            if (pop) begin
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            e_size[head]  <= size;
            e_addr[head]  <= addr;
            e_wdata[head] <= wdata;
        end
    end

    // stores complete early, loads wait for the bridge
    assign data_ok = e_wr[tail] ? wr_ack : b_data_ok;
    assign rdata   = b_rdata;

    assign q_req   = !empty && e_issue[tail];
    assign q_wr    = e_wr[tail];
    assign q_size  = e_size[tail];
    assign q_addr  = e_addr[tail];
    assign q_wdata = e_wdata[tail];

endmodule

`default_nettype wire

// File: verilog/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import sramx_pkg::*, axi_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,

    input  logic                    req,
    input  logic                    wr,
    input  size_t                   size,
    input  logic [sramx_addr_w-1:0] addr,
    input  logic [sramx_data_w-1:0] wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [sramx_data_w-1:0] rdata
);

    // buffer to bridge
    logic                    q_req;
    logic                    q_wr;
    size_t                   q_size;
    logic [sramx_addr_w-1:0] q_addr;
    logic [sramx_data_w-1:0] q_wdata;
    logic                    b_addr_ok;
    logic                    b_data_ok;
    logic [sramx_data_w-1:0] b_rdata;

    // bridge to ram
    logic                    awvalid;
    logic                    awready;
    logic [axi_addr_w-1:0]   awaddr;
    logic                    wvalid;
    logic                    wready;
    logic [axi_data_w-1:0]   wdata_axi;
    logic [axi_strb_w-1:0]   wstrb;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;
    logic                    arvalid;
    logic                    arready;
    logic [axi_addr_w-1:0]   araddr;
    logic                    rvalid;
    logic                    rready;
    logic [axi_data_w-1:0]   rdata_axi;
    logic [1:0]              rresp;

    load_store_buffer u_lsb (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .wr        (wr),
        .size      (size),
        .addr      (addr),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .q_req     (q_req),
        .q_wr      (q_wr),
        .q_size    (q_size),
        .q_addr    (q_addr),
        .q_wdata   (q_wdata),
        .b_addr_ok (b_addr_ok),
        .b_data_ok (b_data_ok),
        .b_rdata   (b_rdata)
    );

    sramx_axi_bridge u_bridge (
        .clk       (clk),
        .resetn    (resetn),
        .q_req     (q_req),
        .q_wr      (q_wr),
        .q_size    (q_size),
        .q_addr    (q_addr),
        .q_wdata   (q_wdata),
        .b_addr_ok (b_addr_ok),
        .b_data_ok (b_data_ok),
        .b_rdata   (b_rdata),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata_axi (wdata_axi),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata_axi (rdata_axi),
        .rresp     (rresp)
    );

    axi_lite_ram u_ram (
        .clk     (clk),
        .resetn  (resetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata_axi),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata_axi),
        .rresp   (rresp)
    );

endmodule

`default_nettype wire

// File: verilog/sramx_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module sramx_axi_bridge
    import sramx_pkg::*, axi_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,

    input  logic                    q_req,
    input  logic                    q_wr,
    input  size_t                   q_size,
    input  logic [sramx_addr_w-1:0] q_addr,
    input  logic [sramx_data_w-1:0] q_wdata,
    output logic                    b_addr_ok,
    output logic                    b_data_ok,
    output logic [sramx_data_w-1:0] b_rdata,

    output logic                    awvalid,
    input  logic                    awready,
    output logic [axi_addr_w-1:0]   awaddr,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [axi_data_w-1:0]   wdata_axi,
    output logic [axi_strb_w-1:0]   wstrb,
    input  logic                    bvalid,
    output logic                    bready,
    input  logic [1:0]              bresp,
    output logic                    arvalid,
    input  logic                    arready,
    output logic [axi_addr_w-1:0]   araddr,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [axi_data_w-1:0]   rdata_axi,
    input  logic [1:0]              rresp
);

    logic                  busy;      // a transaction is open
    logic                  open;
    logic [axi_addr_w-1:0] txn_addr;
    logic [1:0]            rd_off;
    size_t                 rd_size;
    logic [axi_data_w-1:0] rd_lanes;

    function automatic logic [axi_strb_w-1:0] lane_strobe(size_t sz, logic [1:0] off);
        case (sz)
            size_byte: lane_strobe = 4'b0001 << off;
            size_half: lane_strobe = 4'b0011 << {off[1], 1'b0};
            default:   lane_strobe = 4'b1111;
        endcase
    endfunction

    // replicate narrow data so it lands on every lane the strobe may pick
    function automatic logic [axi_data_w-1:0] lane_data(size_t sz, logic [sramx_data_w-1:0] d);
        case (sz)
            size_byte: lane_data = {4{d[7:0]}};
            size_half: lane_data = {2{d[15:0]}};
            default:   lane_data = d;
        endcase
    endfunction

    assign open = !busy && q_req;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy    <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else if (open) begin
            busy    <= 1'b1;
            awvalid <= q_wr;
            wvalid  <= q_wr;
            arvalid <= !q_wr;
        end else begin
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (b_data_ok) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (open) begin
            txn_addr  <= {q_addr[axi_addr_w-1:2], 2'b00};
            wdata_axi <= lane_data(q_size, q_wdata);
            wstrb     <= lane_strobe(q_size, q_addr[1:0]);
            rd_off    <= q_addr[1:0];
            rd_size   <= q_size;
        end
    end

    assign awaddr    = txn_addr;
    assign araddr    = txn_addr;
    assign bready    = 1'b1;
    assign rready    = 1'b1;

    assign b_addr_ok = (awvalid && awready) || (arvalid && arready);
    assign b_data_ok = (bvalid && bready) || (rvalid && rready);

    assign rd_lanes  = rdata_axi >> {rd_off, 3'b000};

    always_comb begin
        case (rd_size)
            size_byte: b_rdata = {{(sramx_data_w - 8){1'b0}}, rd_lanes[7:0]};
            size_half: b_rdata = {{(sramx_data_w - 16){1'b0}}, rd_lanes[15:0]};
            default:   b_rdata = rdata_axi;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/sramx_pkg.sv
`default_nettype none

package sramx_pkg;

    // cpu side request format
    localparam int sramx_addr_w = 32;
    localparam int sramx_data_w = 32;

    // access size, as driven by the cpu on size
    typedef logic [1:0] size_t;

    localparam size_t size_byte = 2'b00;
    localparam size_t size_half = 2'b01;
    localparam size_t size_word = 2'b10;

    // load/store buffer depth, a power of two so the indices wrap on their own
    localparam int lsb_depth   = 4;
    localparam int lsb_index_w = $clog2(lsb_depth);

endpackage

`default_nettype wire
